/* controlUnit.f */
+incdir+.
cuPkg.sv
ctrlBusIf.sv
opcodeDecoder.sv
stepSequencer.sv
controlWordGen.sv
controlUnit.sv
tbControlUnit.sv

/* Bender.yml */
package:
  name: controlUnit

sources:
  - files:
      - cuPkg.sv
      - ctrlBusIf.sv
      - opcodeDecoder.sv
      - stepSequencer.sv
      - controlWordGen.sv
      - controlUnit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbControlUnit.sv

/* tbTasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ------------------------------
// Strobe vector layout
// ------------------------------
localparam int numStrobes = 20;

localparam logic [19:0] mPcOut = 20'd1 << 0;
localparam logic [19:0] mMdrOut = 20'd1 << 1;
localparam logic [19:0] mZLowOut = 20'd1 << 2;
localparam logic [19:0] mRIn = 20'd1 << 3;
localparam logic [19:0] mROut = 20'd1 << 4;
localparam logic [19:0] mGra = 20'd1 << 5;
localparam logic [19:0] mGrb = 20'd1 << 6;
localparam logic [19:0] mGrc = 20'd1 << 7;
localparam logic [19:0] mBaOut = 20'd1 << 8;
localparam logic [19:0] mCSignOut = 20'd1 << 9;
localparam logic [19:0] mMdrIn = 20'd1 << 10;
localparam logic [19:0] mMarIn = 20'd1 << 11;
localparam logic [19:0] mYIn = 20'd1 << 12;
localparam logic [19:0] mIrIn = 20'd1 << 13;
localparam logic [19:0] mPcIn = 20'd1 << 14;
localparam logic [19:0] mConIn = 20'd1 << 15;
localparam logic [19:0] mZLowIn = 20'd1 << 16;
localparam logic [19:0] mIncPc = 20'd1 << 17;
localparam logic [19:0] mMdRead = 20'd1 << 18;
localparam logic [19:0] mWrite = 20'd1 << 19;

// Same order as the masks above
string strobeNames [numStrobes] = '{
	"pcOut", "mdrOut", "zLowOut", "rIn", "rOut",
	"gra", "grb", "grc", "baOut", "cSignOut",
	"mdrIn", "marIn", "yIn", "irIn", "pcIn",
	"conIn", "zLowIn", "incPc", "mdRead", "write"
};

logic [31:0] rngState = 32'd57070;

// 32-bit xorshift
function automatic logic [31:0] nextRandom();
	rngState = rngState ^ (rngState << 13);
	rngState = rngState ^ (rngState >> 17);
	rngState = rngState ^ (rngState << 5);
	return rngState;
endfunction

// ------------------------------
// Instruction rules
// ------------------------------
function automatic instrT kindOf(input opcodeT op);
	case (op)
		opLd: return instrLd;
		opLdi: return instrLdi;
		opSt: return instrSt;
		opAdd, opSub, opAnd, opOr, opShr, opShra, opShl, opRor, opRol: return instrAluReg;
		opAddi, opAndi, opOri: return instrAluImm;
		opNeg, opNot: return instrNegNot;
		opBr: return instrBr;
		opHalt: return instrHalt;
		default: return instrNop;
	endcase
endfunction

function automatic aluOpT ruleAluOp(input opcodeT op);
	case (op)
		opLd, opLdi, opSt, opAdd, opAddi: return aluAdd;
		opSub: return aluSub;
		opAnd, opAndi: return aluAnd;
		opOr, opOri: return aluOr;
		opShr: return aluShr;
		opShra: return aluShra;
		opShl: return aluShl;
		opRor: return aluRor;
		opRol: return aluRol;
		opNeg: return aluNeg;
		opNot: return aluNot;
		opBr: return aluBranch;
		default: return aluNone;
	endcase
endfunction

function automatic int execLength(input instrT kind);
	case (kind)
		instrLd: return ldSteps;
		instrLdi: return ldiSteps;
		instrSt: return stSteps;
		instrAluReg, instrAluImm: return aluSteps;
		instrNegNot: return negSteps;
		instrBr: return brSteps;
		instrHalt: return haltSteps;
		default: return nopSteps;
	endcase
endfunction

// Expected strobes per phase and step
function automatic logic [19:0] expectedStrobes(input phaseT ph, input instrT kind,
		input int st, input logic cond);
	logic [19:0] w;
	w = '0;
	if (ph == phaseFetch) begin
		case (st)
			0: w = mPcOut | mMarIn | mIncPc | mZLowIn;
			1: w = mZLowOut | mPcIn | mMdRead | mMdrIn;
			2: w = mMdrOut | mIrIn;
			default: w = '0;
		endcase
	end else if (ph == phaseExec) begin
		case (kind)
			instrLd, instrLdi, instrSt: begin
				case (st)
					0: w = mGrb | mBaOut | mYIn;
					1: w = mCSignOut | mZLowIn;
					2: w = (kind == instrLdi) ? (mZLowOut | mGra | mRIn) : (mZLowOut | mMarIn);
					3: w = (kind == instrSt) ? (mGra | mBaOut | mWrite) : (mMdRead | mMdrIn);
					4: w = mMdrOut | mGra | mRIn;
					default: w = '0;
				endcase
			end
			instrAluReg, instrAluImm: begin
				case (st)
					0: w = mGrb | mROut | mYIn;
					1: w = (kind == instrAluReg) ? (mGrc | mROut | mZLowIn) : (mCSignOut | mZLowIn);
					2: w = mZLowOut | mGra | mRIn;
					default: w = '0;
				endcase
			end
			instrNegNot: begin
				case (st)
					0: w = mGrb | mROut | mZLowIn;
					1: w = mZLowOut | mGra | mRIn;
					default: w = '0;
				endcase
			end
			instrBr: begin
				case (st)
					0: w = mGra | mROut | mConIn;
					1: w = mPcOut | mYIn;
					2: w = mCSignOut | mZLowIn;
					3: w = cond ? (mZLowOut | mPcIn) : mZLowOut;
					default: w = '0;
				endcase
			end
			default: w = '0;
		endcase
	end
	return w;
endfunction

// ALU operation only on the step that loads Z
function automatic aluOpT expectedAluOp(input phaseT ph, input instrT kind,
		input int st, input opcodeT op);
	int aluStep;
	if (ph != phaseExec)
		return aluNone;
	case (kind)
		instrLd, instrLdi, instrSt, instrAluReg, instrAluImm: aluStep = 1;
		instrNegNot: aluStep = 0;
		instrBr: aluStep = 2;
		default: aluStep = -1;
	endcase
	return (st == aluStep) ? ruleAluOp(op) : aluNone;
endfunction

// ------------------------------
// Compare tasks
// ------------------------------
task automatic checkBit(input string name, input logic actual, input logic expected);
	if (actual !== expected)
		reportFailure($sformatf("Mismatch at %0t ns: %s expected %b got %b",
			$time, name, expected, actual));
endtask

task automatic checkAluOp(input string name, input aluOpT actual, input aluOpT expected);
	if (actual !== expected)
		reportFailure($sformatf("Mismatch at %0t ns: %s expected %s got %s",
			$time, name, expected.name(), actual.name()));
endtask

task automatic checkStrobes(input logic [19:0] expected);
	int i;
	for (i = 0; i < numStrobes; i++)
		checkBit(strobeNames[i], strobes[i], expected[i]);
endtask

// Polls run once per falling edge, gives up after limit cycles
task automatic waitForRun(input logic level, input int limit, output int cycles);
	cycles = 0;
	while (run !== level) begin
		if (cycles >= limit)
			reportFailure($sformatf("Timeout at %0t ns: run did not become %b within %0d cycles",
				$time, level, limit));
		@(negedge clock);
		cycles++;
	end
endtask

`endif

/* tbControlUnit.sv */
`timescale 1ns/10ps
module tbControlUnit import cuPkg::*; ();

	logic clock = 1'b0;
	logic reset;
	logic stop;
	logic conff;
	logic [wordWidth-1:0] irReg;
	logic pcOut, mdrOut, zLowOut, rIn, rOut, gra, grb, grc, baOut, cSignOut;
	logic mdrIn, marIn, yIn, irIn, pcIn, conIn, zLowIn, incPc, mdRead, write;
	logic run;
	logic clear;
	aluOpT aluOp;
	logic [19:0] strobes;

	controlUnit u_dut (
		.clock(clock), .reset(reset), .stop(stop), .conff(conff), .irReg(irReg),
		.pcOut(pcOut), .mdrOut(mdrOut), .zLowOut(zLowOut), .rIn(rIn), .rOut(rOut),
		.gra(gra), .grb(grb), .grc(grc), .baOut(baOut), .cSignOut(cSignOut),
		.mdrIn(mdrIn), .marIn(marIn), .yIn(yIn), .irIn(irIn), .pcIn(pcIn),
		.conIn(conIn), .zLowIn(zLowIn), .incPc(incPc), .mdRead(mdRead), .write(write),
		.run(run), .clear(clear), .aluOp(aluOp)
	);

	// Bit 0 is pcOut, bit 19 is write
	assign strobes = {write, mdRead, incPc, zLowIn, conIn, pcIn, irIn, yIn, marIn, mdrIn,
		cSignOut, baOut, grc, grb, gra, rOut, rIn, zLowOut, mdrOut, pcOut};

	always #10 clock = ~clock;

	task automatic reportFailure(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	`include "tbTasks.svh"

	// All outputs for one cycle, sampled at the falling edge
	task automatic checkCycle(input phaseT ph, input instrT kind, input int st,
			input opcodeT op, input logic cond);
		checkStrobes(expectedStrobes(ph, kind, st, cond));
		checkAluOp("aluOp", aluOp, expectedAluOp(ph, kind, st, op));
		checkBit("run", run, (ph == phaseFetch) || (ph == phaseExec));
		checkBit("clear", clear, ph == phaseReset);
	endtask

	task automatic applyReset();
		int i;
		reset = 1'b1;
		for (i = 0; i < 3; i++) begin
			@(negedge clock);
			checkCycle(phaseReset, instrNop, 0, opNop, 1'b0);
		end
		reset = 1'b0;
	endtask

	// Starts at fetch step 0, ends at the next fetch step 0
	task automatic runInstruction(input opcodeT op, input logic cond);
		logic [31:0] r;
		instrT kind;
		int len;
		int s;
		kind = kindOf(op);
		len = execLength(kind);
		r = nextRandom();
		irReg[opcodeLsb-1:0] = r[opcodeLsb-1:0];
		irReg[opcodeMsb:opcodeLsb] = op;
		conff = cond;
		for (s = 0; s < fetchSteps; s++) begin
			checkCycle(phaseFetch, kind, s, op, cond);
			@(negedge clock);
		end
		for (s = 0; s < len; s++) begin
			checkCycle(phaseExec, kind, s, op, cond);
			@(negedge clock);
		end
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic testReset();
		int waited;
		applyReset();
		waitForRun(1'b1, 4, waited);
		if (waited != 1)
			reportFailure("Fetch did not start one cycle after reset was released");
	endtask

	task automatic testInstructions();
		logic [31:0] r;
		opcodeT ops [7];
		int i;
		ops = '{opLd, opLdi, opSt, opAdd, opAddi, opNeg, opNot};
		for (i = 0; i < 7; i++) begin
			r = nextRandom();
			runInstruction(ops[i], r[0]);
		end
	endtask

	task automatic testBranch();
		runInstruction(opBr, 1'b1);
		runInstruction(opBr, 1'b0);
	endtask

	// Halt is left out, it would end the sequence
	task automatic testRandomOpcodes();
		logic [31:0] r;
		opcodeT op;
		int i;
		for (i = 0; i < 40; i++) begin
			r = nextRandom();
			if (r[4:0] == 5'd27)
				op = opcodeT'(5'd28);
			else
				op = opcodeT'(r[4:0]);
			runInstruction(op, r[5]);
		end
	endtask

	task automatic testStop();
		int i;
		int waited;
		stop = 1'b1;
		runInstruction(opAdd, 1'b0);
		for (i = 0; i < 5; i++) begin
			checkCycle(phaseStopped, instrNop, 0, opNop, 1'b0);
			@(negedge clock);
		end
		checkCycle(phaseStopped, instrNop, 0, opNop, 1'b0);
		stop = 1'b0;
		waitForRun(1'b1, 4, waited);
		if (waited != 1)
			reportFailure("Fetch did not resume one cycle after stop was released");
		runInstruction(opSub, 1'b0);
	endtask

	task automatic testHalt();
		logic [31:0] r;
		int i;
		int waited;
		runInstruction(opHalt, 1'b0);
		// Inputs wander while halted
		for (i = 0; i < 20; i++) begin
			checkCycle(phaseHalted, instrHalt, 0, opHalt, 1'b0);
			r = nextRandom();
			irReg = r;
			stop = r[8];
			conff = r[9];
			@(negedge clock);
		end
		stop = 1'b0;
		applyReset();
		waitForRun(1'b1, 4, waited);
		if (waited != 1)
			reportFailure("Fetch did not restart one cycle after reset following halt");
		runInstruction(opNop, 1'b0);
		checkCycle(phaseFetch, instrNop, 0, opNop, 1'b0);
	endtask

	initial begin
		reset = 1'b1;
		stop = 1'b0;
		conff = 1'b0;
		irReg = '0;
		testReset();
		testInstructions();
		testBranch();
		testRandomOpcodes();
		testStop();
		testHalt();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* controlUnit.sv */
`timescale 1ns/10ps
module controlUnit import cuPkg::*; (
	input logic clock,
	input logic reset,
	input logic stop,
	input logic conff,
	input logic [wordWidth-1:0] irReg,
	output logic pcOut,
	output logic mdrOut,
	output logic zLowOut,
	output logic rIn,
	output logic rOut,
	output logic gra,
	output logic grb,
	output logic grc,
	output logic baOut,
	output logic cSignOut,
	output logic mdrIn,
	output logic marIn,
	output logic yIn,
	output logic irIn,
	output logic pcIn,
	output logic conIn,
	output logic zLowIn,
	output logic incPc,
	output logic mdRead,
	output logic write,
	output logic run,
	output logic clear,
	output aluOpT aluOp
);

	instrT instrDec;
	aluOpT aluOpDec;
	stepT lastStepDec;
	phaseT phase;
	stepT step;
	instrT instrHeld;
	aluOpT aluOpHeld;

	ctrlBusIf ctrlBus ();

	opcodeDecoder uDecoder (
		.opcode(opcodeT'(irReg[opcodeMsb:opcodeLsb])),
		.instr(instrDec),
		.aluOp(aluOpDec),
		.lastStep(lastStepDec)
	);

	stepSequencer uSequencer (
		.clock(clock),
		.reset(reset),
		.stop(stop),
		.instrIn(instrDec),
		.aluOpIn(aluOpDec),
		.lastStepIn(lastStepDec),
		.phase(phase),
		.step(step),
		.instr(instrHeld),
		.aluOp(aluOpHeld),
		.run(run),
		.clear(clear)
	);

	controlWordGen uWordGen (
		.phase(phase),
		.step(step),
		.instr(instrHeld),
		.aluOpIn(aluOpHeld),
		.conff(conff),
		.bus(ctrlBus.driver)
	);

	// Strobes out to the datapath
	assign pcOut = ctrlBus.pcOut;
	assign mdrOut = ctrlBus.mdrOut;
	assign zLowOut = ctrlBus.zLowOut;
	assign rIn = ctrlBus.rIn;
	assign rOut = ctrlBus.rOut;
	assign gra = ctrlBus.gra;
	assign grb = ctrlBus.grb;
	assign grc = ctrlBus.grc;
	assign baOut = ctrlBus.baOut;
	assign cSignOut = ctrlBus.cSignOut;
	assign mdrIn = ctrlBus.mdrIn;
	assign marIn = ctrlBus.marIn;
	assign yIn = ctrlBus.yIn;
	assign irIn = ctrlBus.irIn;
	assign pcIn = ctrlBus.pcIn;
	assign conIn = ctrlBus.conIn;
	assign zLowIn = ctrlBus.zLowIn;
	assign incPc = ctrlBus.incPc;
	assign mdRead = ctrlBus.mdRead;
	assign write = ctrlBus.write;
	assign aluOp = ctrlBus.aluOp;

endmodule

/* controlWordGen.sv */
`timescale 1ns/10ps
module controlWordGen import cuPkg::*; (
	input phaseT phase,
	input stepT step,
	input instrT instr,
	input aluOpT aluOpIn,
	input logic conff,
	ctrlBusIf.driver bus
);

	always_comb begin
		bus.pcOut = 1'b0;
		bus.mdrOut = 1'b0;
		bus.zLowOut = 1'b0;
		bus.rOut = 1'b0;
		bus.baOut = 1'b0;
		bus.cSignOut = 1'b0;
		bus.rIn = 1'b0;
		bus.gra = 1'b0;
		bus.grb = 1'b0;
		bus.grc = 1'b0;
		bus.mdrIn = 1'b0;
		bus.marIn = 1'b0;
		bus.yIn = 1'b0;
		bus.irIn = 1'b0;
		bus.pcIn = 1'b0;
		bus.conIn = 1'b0;
		bus.zLowIn = 1'b0;
		bus.incPc = 1'b0;
		bus.mdRead = 1'b0;
		bus.write = 1'b0;
		bus.aluOp = aluNone;

		if (phase == phaseFetch) begin
			case (step)
				3'd0: begin
					bus.pcOut = 1'b1;
					bus.marIn = 1'b1;
					bus.incPc = 1'b1;
					bus.zLowIn = 1'b1;
				end
				3'd1: begin
					bus.zLowOut = 1'b1;
					bus.pcIn = 1'b1;
					bus.mdRead = 1'b1;
					bus.mdrIn = 1'b1;
				end
				3'd2: begin
					bus.mdrOut = 1'b1;
					bus.irIn = 1'b1;
				end
				default: ;
			endcase
		end else if (phase == phaseExec) begin
			case (instr)
				// ------------------------------
				// Memory group, address is base plus constant
				// ------------------------------
				instrLd, instrLdi, instrSt: begin
					case (step)
						3'd0: begin
							bus.grb = 1'b1;
							bus.baOut = 1'b1;
							bus.yIn = 1'b1;
						end
						3'd1: begin
							bus.cSignOut = 1'b1;
							bus.zLowIn = 1'b1;
							bus.aluOp = aluOpIn;
						end
						3'd2: begin
							bus.zLowOut = 1'b1;
							bus.gra = (instr == instrLdi);
							bus.rIn = (instr == instrLdi);
							bus.marIn = (instr != instrLdi);
						end
						3'd3: begin
							bus.mdRead = (instr == instrLd);
							bus.mdrIn = (instr == instrLd);
							bus.gra = (instr == instrSt);
							bus.baOut = (instr == instrSt);
							bus.write = (instr == instrSt);
						end
						3'd4: begin
							bus.mdrOut = 1'b1;
							bus.gra = 1'b1;
							bus.rIn = 1'b1;
						end
						default: ;
					endcase
				end
				// ------------------------------
				// ALU group, second operand from Rc or constant
				// ------------------------------
				instrAluReg, instrAluImm: begin
					case (step)
						3'd0: begin
							bus.grb = 1'b1;
							bus.rOut = 1'b1;
							bus.yIn = 1'b1;
						end
						3'd1: begin
							bus.grc = (instr == instrAluReg);
							bus.rOut = (instr == instrAluReg);
							bus.cSignOut = (instr == instrAluImm);
							bus.zLowIn = 1'b1;
							bus.aluOp = aluOpIn;
						end
						3'd2: begin
							bus.zLowOut = 1'b1;
							bus.gra = 1'b1;
							bus.rIn = 1'b1;
						end
						default: ;
					endcase
				end
				instrNegNot: begin
					if (step == 3'd0) begin
						bus.grb = 1'b1;
						bus.rOut = 1'b1;
						bus.zLowIn = 1'b1;
						bus.aluOp = aluOpIn;
					end else if (step == 3'd1) begin
						bus.zLowOut = 1'b1;
						bus.gra = 1'b1;
						bus.rIn = 1'b1;
					end
				end
				instrBr: begin
					case (step)
						3'd0: begin
							bus.gra = 1'b1;
							bus.rOut = 1'b1;
							bus.conIn = 1'b1;
						end
						3'd1: begin
							bus.pcOut = 1'b1;
							bus.yIn = 1'b1;
						end
						3'd2: begin
							bus.cSignOut = 1'b1;
							bus.zLowIn = 1'b1;
							bus.aluOp = aluOpIn;
						end
						// Target only reaches PC when the condition held
						3'd3: begin
							bus.zLowOut = 1'b1;
							bus.pcIn = conff;
						end
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	// Memory is single ported
	always_comb begin
		noReadWrite: assert final (!(bus.mdRead && bus.write));
	end

endmodule

/* stepSequencer.sv */
`timescale 1ns/10ps
module stepSequencer import cuPkg::*; (
	input logic clock,
	input logic reset,
	input logic stop,
	input instrT instrIn,
	input aluOpT aluOpIn,
	input stepT lastStepIn,
	output phaseT phase,
	output stepT step,
	output instrT instr,
	output aluOpT aluOp,
	output logic run,
	output logic clear
);

	stepT lastStep;
	phaseT phaseNext;
	stepT stepNext;
	logic fetchDone;
	logic execDone;

	assign fetchDone = (phase == phaseFetch) && (step == stepT'(fetchSteps - 1));
	assign execDone = (phase == phaseExec) && (step == lastStep);

	// ------------------------------
	// Next state
	// ------------------------------
	always_comb begin
		phaseNext = phase;
		stepNext = step;
		case (phase)
			phaseReset: begin
				// Stop is checked whenever fetch step 0 would come next
				phaseNext = stop ? phaseStopped : phaseFetch;
				stepNext = '0;
			end
			phaseFetch: begin
				if (fetchDone) begin
					phaseNext = phaseExec;
					stepNext = '0;
				end else begin
					stepNext = step + 3'd1;
				end
			end
			phaseExec: begin
				if (execDone) begin
					stepNext = '0;
					if (instr == instrHalt)
						phaseNext = phaseHalted;
					else if (stop)
						phaseNext = phaseStopped;
					else
						phaseNext = phaseFetch;
				end else begin
					stepNext = step + 3'd1;
				end
			end
			phaseStopped: begin
				if (!stop)
					phaseNext = phaseFetch;
				stepNext = '0;
			end
			// Halted is only left through reset
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= phaseReset;
			step <= '0;
		end else begin
			phase <= phaseNext;
			step <= stepNext;
		end
	end

	// Decoded instruction, held for the whole execute sequence
	always_ff @(posedge clock) begin
		if (fetchDone) begin
			instr <= instrIn;
			aluOp <= aluOpIn;
			lastStep <= lastStepIn;
		end
	end

	assign run = (phase == phaseFetch) || (phase == phaseExec);
	assign clear = (phase == phaseReset);

	stepInRange: assert property (@(posedge clock) disable iff (reset)
		phase == phaseExec |-> step <= lastStep);

	// Once reset drops, clear lasts a single cycle
	clearOneCycle: assert property (@(posedge clock)
		!reset && clear |=> !clear);

endmodule

/* opcodeDecoder.sv */
`timescale 1ns/10ps
module opcodeDecoder import cuPkg::*; (
	input opcodeT opcode,
	output instrT instr,
	output aluOpT aluOp,
	output stepT lastStep
);

	int steps;

	// Unassigned opcodes run as a no-op
	always_comb begin
		case (opcode)
			opLd: instr = instrLd;
			opLdi: instr = instrLdi;
			opSt: instr = instrSt;
			opAdd, opSub, opAnd, opOr,
			opShr, opShra, opShl, opRor, opRol: instr = instrAluReg;
			opAddi, opAndi, opOri: instr = instrAluImm;
			opNeg, opNot: instr = instrNegNot;
			opBr: instr = instrBr;
			opHalt: instr = instrHalt;
			default: instr = instrNop;
		endcase
	end

	// Memory ops compute the effective address with add
	always_comb begin
		case (opcode)
			opLd, opLdi, opSt, opAdd, opAddi: aluOp = aluAdd;
			opSub: aluOp = aluSub;
			opAnd, opAndi: aluOp = aluAnd;
			opOr, opOri: aluOp = aluOr;
			opShr: aluOp = aluShr;
			opShra: aluOp = aluShra;
			opShl: aluOp = aluShl;
			opRor: aluOp = aluRor;
			opRol: aluOp = aluRol;
			opNeg: aluOp = aluNeg;
			opNot: aluOp = aluNot;
			opBr: aluOp = aluBranch;
			default: aluOp = aluNone;
		endcase
	end

	always_comb begin
		case (instr)
			instrLd: steps = ldSteps;
			instrLdi: steps = ldiSteps;
			instrSt: steps = stSteps;
			instrAluReg, instrAluImm: steps = aluSteps;
			instrNegNot: steps = negSteps;
			instrBr: steps = brSteps;
			instrHalt: steps = haltSteps;
			default: steps = nopSteps;
		endcase
	end

	assign lastStep = stepT'(steps - 1);

	// Longest execute sequence is ld with five steps
	always_comb begin
		lastStepRange: assert final (lastStep <= 3'd4);
	end

endmodule

/* ctrlBusIf.sv */
`timescale 1ns/10ps
interface ctrlBusIf import cuPkg::*; ();

	// Bus drivers
	logic pcOut;
	logic mdrOut;
	logic zLowOut;
	logic rOut;
	logic baOut;
	logic cSignOut;

	// Register file select and enables
	logic rIn;
	logic gra;
	logic grb;
	logic grc;

	// Register loads
	logic mdrIn;
	logic marIn;
	logic yIn;
	logic irIn;
	logic pcIn;
	logic conIn;
	logic zLowIn;
	logic incPc;

	// Memory
	logic mdRead;
	logic write;

	aluOpT aluOp;

	modport driver (
		output pcOut, mdrOut, zLowOut, rOut, baOut, cSignOut,
		output rIn, gra, grb, grc,
		output mdrIn, marIn, yIn, irIn, pcIn, conIn, zLowIn, incPc,
		output mdRead, write, aluOp
	);

	modport sink (
		input pcOut, mdrOut, zLowOut, rOut, baOut, cSignOut,
		input rIn, gra, grb, grc,
		input mdrIn, marIn, yIn, irIn, pcIn, conIn, zLowIn, incPc,
		input mdRead, write, aluOp
	);

endinterface

/* cuPkg.sv */
package cuPkg;

	// ------------------------------
	// Widths and instruction fields
	// ------------------------------
	localparam int wordWidth = 32;
	localparam int opcodeMsb = 31;
	localparam int opcodeLsb = 27;

	// Step counts, fetch and per instruction kind
	localparam int fetchSteps = 3;
	localparam int ldSteps = 5;
	localparam int ldiSteps = 3;
	localparam int stSteps = 4;
	localparam int aluSteps = 3;
	localparam int negSteps = 2;
	localparam int brSteps = 4;
	localparam int nopSteps = 1;
	localparam int haltSteps = 1;

	// ------------------------------
	// Types
	// ------------------------------
	typedef logic [2:0] stepT;

	// Opcode encodings of the processor ISA, gaps are unassigned
	typedef enum logic [opcodeMsb-opcodeLsb:0] {
		opLd = 5'd0,
		opLdi = 5'd1,
		opSt = 5'd2,
		opAdd = 5'd3,
		opSub = 5'd4,
		opShr = 5'd5,
		opShra = 5'd6,
		opShl = 5'd7,
		opRor = 5'd8,
		opRol = 5'd9,
		opAnd = 5'd10,
		opOr = 5'd11,
		opAddi = 5'd12,
		opAndi = 5'd13,
		opOri = 5'd14,
		opNeg = 5'd17,
		opNot = 5'd18,
		opBr = 5'd19,
		opNop = 5'd26,
		opHalt = 5'd27
	} opcodeT;

	// Instructions grouped by their execute sequence
	typedef enum logic [3:0] {
		instrLd,
		instrLdi,
		instrSt,
		instrAluReg,
		instrAluImm,
		instrNegNot,
		instrBr,
		instrNop,
		instrHalt
	} instrT;

	typedef enum logic [3:0] {
		aluNone,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluShr,
		aluShra,
		aluShl,
		aluRor,
		aluRol,
		aluNeg,
		aluNot,
		aluBranch
	} aluOpT;

	typedef enum logic [2:0] {
		phaseReset,
		phaseFetch,
		phaseExec,
		phaseStopped,
		phaseHalted
	} phaseT;

endpackage
